/* logic/exc_pkg.sv */
// Shared widths, types and constants for the exception entry and return unit
// Imported by every RTL module of the unit

package exc_pkg;

    // Core address and context widths
    parameter int PC_W   = 13;
    parameter int DATA_W = 16;
    parameter int CODE_W = 4;

    // One table entry per code value
    parameter int VEC_ENTRIES = 2 ** CODE_W;

    typedef logic [PC_W-1:0]   pc_t;
    typedef logic [DATA_W-1:0] data_t;
    typedef logic [CODE_W-1:0] code_t;

    // Entry n comes up as base + n * stride
    parameter pc_t VEC_RESET_BASE   = 13'h100;
    parameter pc_t VEC_RESET_STRIDE = 13'h010;

    // Controller sequencing
    typedef enum logic [2:0] {
        IDLE    = 3'd0,  // Waiting for a strobe
        SAVE    = 3'd1,  // Push pc and data
        LOAD    = 3'd2,  // Fetch handler address
        ACK     = 3'd3,  // Entry acknowledge
        RESTORE = 3'd4,  // Pop saved pair
        RETURN  = 3'd5   // Return acknowledge
    } exc_state_e;

endpackage

/* logic/exc_vector_table.sv */
// Writable table of handler addresses, one per exception code
// Written by a plain strobe, read combinationally by the controller
`timescale 1ns/1ns

module exc_vector_table (
    input  logic          clk,
    input  logic          pon_rst_n_i,
    input  logic          wr_i,
    input  exc_pkg::code_t wr_idx_i,
    input  exc_pkg::pc_t  wr_addr_i,
    input  exc_pkg::code_t rd_idx_i,
    output exc_pkg::pc_t  rd_addr_o
);

    import exc_pkg::*;

    pc_t table_q [VEC_ENTRIES];

    // Reset loads the fixed base-plus-stride pattern
    always_ff @(posedge clk or negedge pon_rst_n_i) begin
        if (!pon_rst_n_i) begin
            for (int i = 0; i < VEC_ENTRIES; i++) begin
                table_q[i] <= VEC_RESET_BASE + pc_t'(i) * VEC_RESET_STRIDE;
            end
        end else if (wr_i) begin
            table_q[wr_idx_i] <= wr_addr_i;  // Visible from the next cycle
        end
    end

    assign rd_addr_o = table_q[rd_idx_i];

endmodule

/* logic/exc_context_stack.sv */
// LIFO of interrupted pc and data pairs for nested exceptions
// Push and pop come from the controller, which guards full and empty
`timescale 1ns/1ns

module exc_context_stack #(
    parameter int STACK_DEPTH = 64
) (
    input  logic          clk,
    input  logic          pon_rst_n_i,
    input  logic          push_i,
    input  logic          pop_i,
    input  exc_pkg::pc_t  pc_i,
    input  exc_pkg::data_t data_i,
    output exc_pkg::pc_t  top_pc_o,
    output exc_pkg::data_t top_data_o,
    output logic          full_o,
    output logic          empty_o,
    output logic          depth_one_o
);

    import exc_pkg::*;

    localparam int AW    = $clog2(STACK_DEPTH);
    localparam int PTR_W = AW + 1;  // Counts 0 up to STACK_DEPTH

    pc_t   pc_mem   [STACK_DEPTH];
    data_t data_mem [STACK_DEPTH];

    logic [PTR_W-1:0] ptr_q;  // Number of stored entries
    logic [AW-1:0]    wr_idx;
    logic [AW-1:0]    top_idx;

    assign wr_idx  = ptr_q[AW-1:0];
    assign top_idx = ptr_q[AW-1:0] - 1'b1;  // Wraps correctly when full

    always_ff @(posedge clk or negedge pon_rst_n_i) begin
        if (!pon_rst_n_i) begin
            ptr_q <= '0;
        end else if (push_i) begin
            ptr_q <= ptr_q + 1'b1;
        end else if (pop_i) begin
            ptr_q <= ptr_q - 1'b1;
        end
    end

    // Context storage
    always_ff @(posedge clk) begin
        if (push_i) begin
            pc_mem[wr_idx]   <= pc_i;
            data_mem[wr_idx] <= data_i;
        end
    end

    assign top_pc_o   = pc_mem[top_idx];
    assign top_data_o = data_mem[top_idx];

    // Flags straight from the registered pointer
    assign full_o      = (ptr_q == PTR_W'(STACK_DEPTH));
    assign empty_o     = (ptr_q == '0);
    assign depth_one_o = (ptr_q == PTR_W'(1));

endmodule

/* logic/exc_controller.sv */
// Sequences exception entry and return and owns all unit outputs
// Drives the table index and the stack push and pop strobes
`timescale 1ns/1ns

module exc_controller #(
    parameter int STACK_DEPTH = 64
) (
    input  logic          clk,
    input  logic          pon_rst_n_i,
    input  logic          request_i,
    input  exc_pkg::code_t code_i,
    input  logic          return_i,
    input  exc_pkg::pc_t  vec_addr_i,
    input  logic          stack_full_i,
    input  logic          stack_empty_i,
    input  logic          stack_depth_one_i,
    input  exc_pkg::pc_t  top_pc_i,
    input  exc_pkg::data_t top_data_i,
    output exc_pkg::code_t vec_idx_o,
    output logic          push_o,
    output logic          pop_o,
    output exc_pkg::pc_t  vector_o,
    output logic          active_o,
    output logic          ack_o,
    output logic          fault_o,
    output exc_pkg::data_t saved_data_o
);

    import exc_pkg::*;

    // Stack pointer arithmetic needs a power of two
    if (STACK_DEPTH < 2 || (STACK_DEPTH & (STACK_DEPTH - 1)) != 0) begin : g_depth_check
        $error("STACK_DEPTH must be a power of two, 2 or more");
    end

    exc_state_e state_q;
    code_t      code_q;    // Code of the exception being entered
    logic       last_q;    // Pop takes the outermost level
    logic       refuse_q;  // Refused strobe, reported one cycle later

    assign vec_idx_o = code_q;
    assign push_o    = (state_q == SAVE);
    assign pop_o     = (state_q == RESTORE);

    always_ff @(posedge clk or negedge pon_rst_n_i) begin
        if (!pon_rst_n_i) begin
            state_q      <= IDLE;
            code_q       <= '0;
            last_q       <= 1'b0;
            refuse_q     <= 1'b0;
            vector_o     <= '0;
            saved_data_o <= '0;
            active_o     <= 1'b0;
            ack_o        <= 1'b0;
            fault_o      <= 1'b0;
        end else begin
            ack_o    <= 1'b0;      // Pulses only
            fault_o  <= refuse_q;
            refuse_q <= 1'b0;
            case (state_q)
                IDLE: begin
                    // Request takes priority over return
                    if (request_i) begin
                        if (stack_full_i) begin
                            refuse_q <= 1'b1;
                        end else begin
                            code_q  <= code_i;
                            state_q <= SAVE;
                        end
                    end else if (return_i) begin
                        if (stack_empty_i) begin
                            refuse_q <= 1'b1;
                        end else begin
                            state_q <= RESTORE;
                        end
                    end
                end
                SAVE: state_q <= LOAD;  // Push happens on this edge
                LOAD: begin
                    vector_o <= vec_addr_i;
                    active_o <= 1'b1;
                    state_q  <= ACK;
                end
                ACK: begin
                    ack_o   <= 1'b1;
                    state_q <= IDLE;
                end
                RESTORE: begin
                    vector_o     <= top_pc_i;      // Resume address
                    saved_data_o <= top_data_i;
                    last_q       <= stack_depth_one_i;
                    state_q      <= RETURN;
                end
                RETURN: begin
                    ack_o <= 1'b1;
                    if (last_q) begin
                        active_o <= 1'b0;  // Outermost level done
                    end
                    state_q <= IDLE;
                end
                default: state_q <= IDLE;
            endcase
        end
    end

endmodule

/* logic/exc_host_top.sv */
// Top level of the exception entry and return unit
// Connects controller, vector table and context stack
`timescale 1ns/1ns

module exc_host_top #(
    parameter int STACK_DEPTH = 64
) (
    input  logic           clk,
    input  logic           pon_rst_n_i,
    input  logic           exception_request_i,
    input  exc_pkg::code_t exception_code_i,
    input  exc_pkg::pc_t   exception_pc_i,
    input  exc_pkg::data_t exception_data_i,
    input  logic           return_from_exception_i,
    input  logic           vec_wr_i,
    input  exc_pkg::code_t vec_wr_idx_i,
    input  exc_pkg::pc_t   vec_wr_addr_i,
    output exc_pkg::pc_t   exception_vector_o,
    output logic           exception_active_o,
    output logic           exception_ack_o,
    output logic           exception_fault_o,
    output exc_pkg::data_t saved_data_o
);

    import exc_pkg::*;

    code_t rd_idx;
    pc_t   rd_addr;
    logic  push;
    logic  pop;
    pc_t   top_pc;
    data_t top_data;
    logic  full;
    logic  empty;
    logic  depth_one;

    exc_controller #(
        .STACK_DEPTH(STACK_DEPTH)
    ) u_ctrl (
        .clk              (clk),
        .pon_rst_n_i      (pon_rst_n_i),
        .request_i        (exception_request_i),
        .code_i           (exception_code_i),
        .return_i         (return_from_exception_i),
        .vec_addr_i       (rd_addr),
        .stack_full_i     (full),
        .stack_empty_i    (empty),
        .stack_depth_one_i(depth_one),
        .top_pc_i         (top_pc),
        .top_data_i       (top_data),
        .vec_idx_o        (rd_idx),
        .push_o           (push),
        .pop_o            (pop),
        .vector_o         (exception_vector_o),
        .active_o         (exception_active_o),
        .ack_o            (exception_ack_o),
        .fault_o          (exception_fault_o),
        .saved_data_o     (saved_data_o)
    );

    exc_vector_table u_table (
        .clk        (clk),
        .pon_rst_n_i(pon_rst_n_i),
        .wr_i       (vec_wr_i),
        .wr_idx_i   (vec_wr_idx_i),
        .wr_addr_i  (vec_wr_addr_i),
        .rd_idx_i   (rd_idx),
        .rd_addr_o  (rd_addr)
    );

    // Interrupted context goes straight to the stack write side
    exc_context_stack #(
        .STACK_DEPTH(STACK_DEPTH)
    ) u_stack (
        .clk        (clk),
        .pon_rst_n_i(pon_rst_n_i),
        .push_i     (push),
        .pop_i      (pop),
        .pc_i       (exception_pc_i),
        .data_i     (exception_data_i),
        .top_pc_o   (top_pc),
        .top_data_o (top_data),
        .full_o     (full),
        .empty_o    (empty),
        .depth_one_o(depth_one)
    );

endmodule

/* testbench/tb_clock_gen.sv */
// Free-running testbench clock and power-on reset
// Reset is held low for RESET_CYCLES periods and released on a falling edge
`timescale 1ns/1ns

module tb_clock_gen #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 10
) (
    output logic clk,
    output logic pon_rst_n_o
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    initial begin
        pon_rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        pon_rst_n_o = 1'b1;  // Away from the sampling edge
    end

endmodule

/* testbench/exc_host_properties.sv */
// Concurrent checks on the exception controller outputs
// Attached to every exc_controller instance by the bind at the end
`timescale 1ns/1ns

module exc_host_properties (
    input logic clk,
    input logic pon_rst_n_i,
    input logic ack_i,
    input logic fault_i,
    input logic push_i,
    input logic pop_i,
    input logic active_i
);

    logic pushed_q;  // First push seen since reset

    always_ff @(posedge clk or negedge pon_rst_n_i) begin
        if (!pon_rst_n_i) begin
            pushed_q <= 1'b0;
        end else if (push_i) begin
            pushed_q <= 1'b1;
        end
    end

    a_ack_single: assert property (@(posedge clk) disable iff (!pon_rst_n_i)
        ack_i |=> !ack_i)
        else $error("exception ack high for two cycles in a row");

    a_fault_ack_excl: assert property (@(posedge clk) disable iff (!pon_rst_n_i)
        !(fault_i && ack_i))
        else $error("fault and ack high together");

    a_push_pop_excl: assert property (@(posedge clk) disable iff (!pon_rst_n_i)
        !(push_i && pop_i))
        else $error("push and pop high together");

    // Nothing can be active before anything was stacked
    a_idle_after_reset: assert property (@(posedge clk) disable iff (!pon_rst_n_i)
        !pushed_q |-> !active_i)
        else $error("active high before the first push");

endmodule

bind exc_controller exc_host_properties u_props (
    .clk        (clk),
    .pon_rst_n_i(pon_rst_n_i),
    .ack_i      (ack_o),
    .fault_i    (fault_o),
    .push_i     (push_o),
    .pop_i      (pop_o),
    .active_i   (active_o)
);

/* testbench/exc_host_tb.sv */
// Random testbench for the exception unit, checked against a cycle model
// Top module of the simulation, prints the error count and the result line
`timescale 1ns/1ns

module exc_host_tb;

    import exc_pkg::*;

    localparam int STACK_DEPTH   = 4;     // Small so full and empty come up often
    localparam int NUM_OPS       = 400;
    localparam int SWEEP_OPS     = 32;    // Request and return for every code
    localparam int OP_CYCLES     = 8;     // Longest operation plus idle gap
    localparam int CLK_PERIOD_NS = 100;
    localparam int WATCHDOG_NS   =
        ((NUM_OPS + SWEEP_OPS) * OP_CYCLES + 100) * CLK_PERIOD_NS;

    logic  clk;
    logic  pon_rst_n;
    logic  exception_request;
    code_t exception_code;
    pc_t   exception_pc;
    data_t exception_data;
    logic  return_from_exception;
    logic  vec_wr;
    code_t vec_wr_idx;
    pc_t   vec_wr_addr;
    pc_t   exception_vector;
    logic  exception_active;
    logic  exception_ack;
    logic  exception_fault;
    data_t saved_data;

    // Reference model state
    pc_t    model_table [16];
    pc_t    model_pc_q [$];
    data_t  model_data_q [$];
    pc_t    model_vector;
    data_t  model_saved;
    logic   model_active;
    integer seed;
    int     error_count;
    int     refusal_count;

    tb_clock_gen #(
        .PERIOD_NS   (CLK_PERIOD_NS),
        .RESET_CYCLES(10)
    ) u_clk (
        .clk        (clk),
        .pon_rst_n_o(pon_rst_n)
    );

    exc_host_top #(
        .STACK_DEPTH(STACK_DEPTH)
    ) uut (
        .clk                    (clk),
        .pon_rst_n_i            (pon_rst_n),
        .exception_request_i    (exception_request),
        .exception_code_i       (exception_code),
        .exception_pc_i         (exception_pc),
        .exception_data_i       (exception_data),
        .return_from_exception_i(return_from_exception),
        .vec_wr_i               (vec_wr),
        .vec_wr_idx_i           (vec_wr_idx),
        .vec_wr_addr_i          (vec_wr_addr),
        .exception_vector_o     (exception_vector),
        .exception_active_o     (exception_active),
        .exception_ack_o        (exception_ack),
        .exception_fault_o      (exception_fault),
        .saved_data_o           (saved_data)
    );

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        error_count++;
        $display("** Error: %s = 0x%0h, expected 0x%0h at %0t ns", name, got, exp, $time);
    endtask

    // Compares every output with the model, sampled mid-cycle
    task automatic check_outputs(input logic exp_ack, input logic exp_fault);
        if (exception_ack !== exp_ack)
            report_mismatch("exception_ack_o", 32'(exception_ack), 32'(exp_ack));
        if (exception_fault !== exp_fault)
            report_mismatch("exception_fault_o", 32'(exception_fault), 32'(exp_fault));
        if (exception_active !== model_active)
            report_mismatch("exception_active_o", 32'(exception_active), 32'(model_active));
        if (exception_vector !== model_vector)
            report_mismatch("exception_vector_o", 32'(exception_vector), 32'(model_vector));
        if (saved_data !== model_saved)
            report_mismatch("saved_data_o", 32'(saved_data), 32'(model_saved));
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(negedge clk);
            check_outputs(1'b0, 1'b0);
        end
    endtask

    // Called one cycle after the refused strobe was sampled
    task automatic check_refusal();
        check_outputs(1'b0, 1'b0);
        @(negedge clk);
        check_outputs(1'b0, 1'b1);  // Single fault cycle after edge N+1
        @(negedge clk);
        check_outputs(1'b0, 1'b0);
        refusal_count++;
    endtask

    task automatic do_request(input code_t code, input logic with_return);
        pc_t   pc;
        data_t data;
        pc                    = pc_t'($random(seed));
        data                  = data_t'($random(seed));
        exception_request     = 1'b1;
        return_from_exception = with_return;  // Request must win
        exception_code        = code;
        exception_pc          = pc;
        exception_data        = data;
        @(negedge clk);                       // Edge N took the strobe
        exception_request     = 1'b0;
        return_from_exception = 1'b0;
        exception_code        = code_t'($random(seed));  // Code was latched
        if (model_pc_q.size() == STACK_DEPTH) begin
            check_refusal();
        end else begin
            check_outputs(1'b0, 1'b0);
            @(negedge clk);                   // Pushed at edge N+1
            exception_pc   = pc_t'($random(seed));
            exception_data = data_t'($random(seed));
            model_pc_q.push_back(pc);
            model_data_q.push_back(data);
            check_outputs(1'b0, 1'b0);
            @(negedge clk);                   // Vector loaded at edge N+2
            model_vector = model_table[code];
            model_active = 1'b1;
            check_outputs(1'b0, 1'b0);
            @(negedge clk);
            check_outputs(1'b1, 1'b0);
            @(negedge clk);
            check_outputs(1'b0, 1'b0);
        end
    endtask

    task automatic do_return();
        return_from_exception = 1'b1;
        @(negedge clk);
        return_from_exception = 1'b0;
        if (model_pc_q.size() == 0) begin
            check_refusal();
        end else begin
            check_outputs(1'b0, 1'b0);
            @(negedge clk);                   // Popped pair after edge N+1
            model_vector = model_pc_q.pop_back();
            model_saved  = model_data_q.pop_back();
            check_outputs(1'b0, 1'b0);
            @(negedge clk);
            if (model_pc_q.size() == 0) model_active = 1'b0;  // Outermost return
            check_outputs(1'b1, 1'b0);
            @(negedge clk);
            check_outputs(1'b0, 1'b0);
        end
    endtask

    task automatic do_table_write(input code_t idx, input pc_t addr);
        vec_wr      = 1'b1;
        vec_wr_idx  = idx;
        vec_wr_addr = addr;
        @(negedge clk);
        vec_wr      = 1'b0;
        model_table[idx] = addr;
        check_outputs(1'b0, 1'b0);
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired: the run did not finish in the expected time");
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        logic [31:0] sel;
        seed                  = 32'hf130;
        error_count           = 0;
        refusal_count         = 0;
        exception_request     = 1'b0;
        exception_code        = '0;
        exception_pc          = '0;
        exception_data        = '0;
        return_from_exception = 1'b0;
        vec_wr                = 1'b0;
        vec_wr_idx            = '0;
        vec_wr_addr           = '0;
        for (int n = 0; n < 16; n++) begin
            model_table[n] = 13'h100 + 13'(n) * 13'h010;
        end
        model_vector = '0;
        model_saved  = '0;
        model_active = 1'b0;

        @(posedge pon_rst_n);
        @(negedge clk);
        check_outputs(1'b0, 1'b0);

        // Each code once against the reset pattern
        for (int n = 0; n < 16; n++) begin
            do_request(code_t'(n), 1'b0);
            do_return();
        end

        for (int op = 0; op < NUM_OPS; op++) begin
            sel = $random(seed);
            case (sel[2:0])
                3'd0, 3'd1, 3'd2: do_request(code_t'(sel[11:8]), sel[3]);
                3'd3, 3'd4, 3'd5: do_return();
                3'd6: do_table_write(code_t'(sel[15:12]), pc_t'($random(seed)));
                default: idle_cycles(1);
            endcase
            idle_cycles(int'(sel[5:4]));
        end

        $display("Run complete: %0d operations, %0d refusals, %0d errors",
                 NUM_OPS + SWEEP_OPS, refusal_count, error_count);
        if (error_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* sources.f */
logic/exc_pkg.sv
logic/exc_vector_table.sv
logic/exc_context_stack.sv
logic/exc_controller.sv
logic/exc_host_top.sv
testbench/tb_clock_gen.sv
testbench/exc_host_properties.sv
testbench/exc_host_tb.sv

/* Makefile */
# Verilator build, run and lint for the exception unit
# Override any variable on the command line, e.g. make LOG=run1.log

VERILATOR  ?= verilator
TOP        ?= exc_host_tb
RTL_TOP    ?= exc_host_top
FILELIST   ?= sources.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing
PASS_MSG   := TEST RESULT: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
